// File: logic/matmul_pkg.sv
package matmul_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes and widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int MAT_SIZE   = 4;
  localparam int DATA_WIDTH = 8;
  localparam int ADDR_WIDTH = 10;
  localparam int ROW_WIDTH  = MAT_SIZE * DATA_WIDTH;
  localparam int CNT_WIDTH  = 7;

  ////////////////////////////////////////////////////////////////////////////
  // latencies and run cycles
  ////////////////////////////////////////////////////////////////////////////

  localparam int MEM_LATENCY = 1;
  localparam int MAC_STAGES  = 3;

  // last word, first data cycle, worst lane skew, grid path to cell (3,3), mac pipe
  localparam int LATCH_CYCLE = (MAT_SIZE - 1) + 1 + MEM_LATENCY + 2 * (MAT_SIZE - 1)
                               + MAC_STAGES;
  localparam int DONE_CYCLE  = LATCH_CYCLE + MAT_SIZE + 1;

endpackage

// File: logic/processing_element.sv
`timescale 1ns/10ps

module processing_element (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [matmul_pkg::DATA_WIDTH-1:0] i_a,
  input  logic [matmul_pkg::DATA_WIDTH-1:0] i_b,
  output logic [matmul_pkg::DATA_WIDTH-1:0] o_a,
  output logic [matmul_pkg::DATA_WIDTH-1:0] o_b,
  output logic [matmul_pkg::DATA_WIDTH-1:0] o_sum
);

  import matmul_pkg::*;

  logic [2*DATA_WIDTH-1:0] product_q;
  logic [DATA_WIDTH:0]     product_top;
  logic [DATA_WIDTH-1:0]   product_sat;

  // stage 1, operand register doubles as the forward path to the neighbours
  always_ff @(posedge clk) begin
    if (reset) begin
      o_a <= '0;
      o_b <= '0;
    end else begin
      o_a <= i_a;
      o_b <= i_b;
    end
  end

  // stage 2, full signed product
  always_ff @(posedge clk) begin
    if (reset) begin
      product_q <= '0;
    end else begin
      product_q <= $signed(o_a) * $signed(o_b);
    end
  end

  // clamp to the signed byte range when the upper bits are not a sign extension
  assign product_top = product_q[2*DATA_WIDTH-1:DATA_WIDTH-1];

  always_comb begin
    if (product_top == '0 || product_top == '1) begin
      product_sat = product_q[DATA_WIDTH-1:0];
    end else begin
      product_sat = {product_q[2*DATA_WIDTH-1], {(DATA_WIDTH-1){~product_q[2*DATA_WIDTH-1]}}};
    end
  end

  // stage 3, running sum wraps at 8 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      o_sum <= '0;
    end else begin
      o_sum <= o_sum + product_sat;
    end
  end

endmodule

// File: logic/pe_array.sv
`timescale 1ns/10ps

module pe_array (
  input  logic clk,
  input  logic reset,
  input  logic [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::DATA_WIDTH-1:0] i_a_lanes,
  input  logic [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::DATA_WIDTH-1:0] i_b_lanes,
  output logic [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::MAT_SIZE-1:0]
               [matmul_pkg::DATA_WIDTH-1:0] o_sums
);

  import matmul_pkg::*;

  // forwarded operands of cell (i,j), indexed [row][col]
  logic [MAT_SIZE-1:0][MAT_SIZE-1:0][DATA_WIDTH-1:0] a_fwd;
  logic [MAT_SIZE-1:0][MAT_SIZE-1:0][DATA_WIDTH-1:0] b_fwd;

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      logic [DATA_WIDTH-1:0] a_in;
      logic [DATA_WIDTH-1:0] b_in;

      // a enters on the left edge and moves right
      if (j == 0) begin : g_a_edge
        assign a_in = i_a_lanes[i];
      end else begin : g_a_link
        assign a_in = a_fwd[i][j-1];
      end

      // b enters on the top edge and moves down
      if (i == 0) begin : g_b_edge
        assign b_in = i_b_lanes[j];
      end else begin : g_b_link
        assign b_in = b_fwd[i-1][j];
      end

      processing_element pe_inst (
        .clk   (clk),
        .reset (reset),
        .i_a   (a_in),
        .i_b   (b_in),
        .o_a   (a_fwd[i][j]),
        .o_b   (b_fwd[i][j]),
        .o_sum (o_sums[i][j])
      );
    end
  end

endmodule

// File: logic/operand_fetch.sv
`timescale 1ns/10ps

module operand_fetch (
  input  logic                                                   clk,
  input  logic                                                   reset,
  input  logic                                                   i_start,
  input  logic [matmul_pkg::CNT_WIDTH-1:0]                       i_count,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0]                      i_base,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]                       i_data,
  output logic [matmul_pkg::ADDR_WIDTH-1:0]                      o_addr,
  output logic [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::DATA_WIDTH-1:0] o_lanes
);

  import matmul_pkg::*;

  logic                                data_valid;
  logic [MAT_SIZE-1:0][DATA_WIDTH-1:0] masked;

  ////////////////////////////////////////////////////////////////////////////
  // read address
  ////////////////////////////////////////////////////////////////////////////

  // parks one step below base, walks base+0..12 during counts 0 to 3
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_addr <= i_base - ADDR_WIDTH'(MAT_SIZE);
    end else if (i_count < CNT_WIDTH'(MAT_SIZE)) begin
      o_addr <= o_addr + ADDR_WIDTH'(MAT_SIZE);
    end else begin
      o_addr <= i_base - ADDR_WIDTH'(MAT_SIZE);
    end
  end

  // word k is on the address bus in count k+1 and returns MEM_LATENCY later
  assign data_valid = (i_count > CNT_WIDTH'(MEM_LATENCY)) &&
                      (i_count <= CNT_WIDTH'(MEM_LATENCY + MAT_SIZE));

  assign masked = data_valid ? i_data : '0;

  ////////////////////////////////////////////////////////////////////////////
  // lane skew, lane i trails lane 0 by i cycles
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign o_lanes[i] = masked[i];
    end else begin : g_skew
      logic [DATA_WIDTH-1:0] taps [i];

      always_ff @(posedge clk) begin
        if (reset || !i_start) begin
          for (int d = 0; d < i; d++) begin
            taps[d] <= '0;
          end
        end else begin
          taps[0] <= masked[i];
          for (int d = 1; d < i; d++) begin
            taps[d] <= taps[d-1];
          end
        end
      end

      assign o_lanes[i] = taps[i-1];
    end
  end

endmodule

// File: logic/matmul_control.sv
`timescale 1ns/10ps

module matmul_control (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             i_start,
  output logic [matmul_pkg::CNT_WIDTH-1:0] o_count,
  output logic                             o_latch,
  output logic                             o_done
);

  import matmul_pkg::*;

  // run cycle counter, restarts whenever start drops
  // holds at the top so a long start never replays the run
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_count <= '0;
    end else if (o_count != '1) begin
      o_count <= o_count + 1'b1;
    end
  end

  // grid results are final in exactly this cycle
  assign o_latch = (o_count == CNT_WIDTH'(LATCH_CYCLE));

  // single done pulse, after the last result column has left
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_done <= 1'b0;
    end else begin
      o_done <= (o_count == CNT_WIDTH'(DONE_CYCLE));
    end
  end

endmodule

// File: logic/result_drain.sv
`timescale 1ns/10ps

module result_drain (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              i_start,
  input  logic                              i_latch,
  input  logic [matmul_pkg::MAT_SIZE-1:0][matmul_pkg::MAT_SIZE-1:0]
               [matmul_pkg::DATA_WIDTH-1:0] i_sums,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] i_base_c,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] o_c_addr,
  output logic [matmul_pkg::ROW_WIDTH-1:0]  o_c_data,
  output logic                              o_c_valid
);

  import matmul_pkg::*;

  // snapshot held transposed, [col][row], so column 0 is the low word
  logic [MAT_SIZE-1:0][MAT_SIZE-1:0][DATA_WIDTH-1:0] cols_q;
  // one bit per column still to be sent
  logic [MAT_SIZE-1:0]                               live;

  always_ff @(posedge clk) begin
    if (i_latch) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        for (int i = 0; i < MAT_SIZE; i++) begin
          cols_q[j][i] <= i_sums[i][j];
        end
      end
    end else if (live[0]) begin
      cols_q <= cols_q >> ROW_WIDTH;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      live <= '0;
    end else if (i_latch) begin
      live <= '1;
    end else begin
      live <= live >> 1;
    end
  end

  // address follows the column, back to base minus one step once drained
  always_ff @(posedge clk) begin
    if (reset || !i_start) begin
      o_c_addr <= i_base_c - ADDR_WIDTH'(MAT_SIZE);
    end else if (i_latch) begin
      o_c_addr <= i_base_c;
    end else if (live[1]) begin
      o_c_addr <= o_c_addr + ADDR_WIDTH'(MAT_SIZE);
    end else begin
      o_c_addr <= i_base_c - ADDR_WIDTH'(MAT_SIZE);
    end
  end

  assign o_c_data  = cols_q[0];
  assign o_c_valid = live[0];

endmodule

// File: logic/matmul_top.sv
`timescale 1ns/10ps

module matmul_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              i_start,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] i_addr_a,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] i_addr_b,
  input  logic [matmul_pkg::ADDR_WIDTH-1:0] i_addr_c,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]  i_a_data,
  input  logic [matmul_pkg::ROW_WIDTH-1:0]  i_b_data,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] o_a_addr,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] o_b_addr,
  output logic [matmul_pkg::ADDR_WIDTH-1:0] o_c_addr,
  output logic [matmul_pkg::ROW_WIDTH-1:0]  o_c_data,
  output logic                              o_c_valid,
  output logic                              o_done
);

  import matmul_pkg::*;

  logic [CNT_WIDTH-1:0]                              count;
  logic                                              latch;
  logic                                              grid_clear;
  logic [MAT_SIZE-1:0][DATA_WIDTH-1:0]               a_lanes;
  logic [MAT_SIZE-1:0][DATA_WIDTH-1:0]               b_lanes;
  logic [MAT_SIZE-1:0][MAT_SIZE-1:0][DATA_WIDTH-1:0] sums;

  // grid sums restart with every run
  assign grid_clear = reset || !i_start;

  matmul_control u_control (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .o_count (count),
    .o_latch (latch),
    .o_done  (o_done)
  );

  operand_fetch u_fetch_a (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .i_count (count),
    .i_base  (i_addr_a),
    .i_data  (i_a_data),
    .o_addr  (o_a_addr),
    .o_lanes (a_lanes)
  );

  operand_fetch u_fetch_b (
    .clk     (clk),
    .reset   (reset),
    .i_start (i_start),
    .i_count (count),
    .i_base  (i_addr_b),
    .i_data  (i_b_data),
    .o_addr  (o_b_addr),
    .o_lanes (b_lanes)
  );

  pe_array u_array (
    .clk       (clk),
    .reset     (grid_clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_sums    (sums)
  );

  result_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_latch   (latch),
    .i_sums    (sums),
    .i_base_c  (i_addr_c),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data),
    .o_c_valid (o_c_valid)
  );

endmodule

// File: tests/matmul_sva.sv
`timescale 1ns/10ps

module matmul_sva (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic i_c_valid,
  input logic i_done
);

  // done is a single cycle pulse
  a_done_single: assert property (@(posedge clk) disable iff (reset)
    i_done |=> !i_done)
    else $error("done stayed high for two cycles");

  // a dropped start clears the result strobe on the next edge
  a_valid_needs_start: assert property (@(posedge clk) disable iff (reset)
    !$past(i_start) |-> !i_c_valid)
    else $error("result strobe high one cycle after start was low");

  a_done_after_results: assert property (@(posedge clk) disable iff (reset)
    $rose(i_done) |-> !i_c_valid)
    else $error("done rose while a result column was still out");

endmodule

bind matmul_top matmul_sva matmul_sva_inst (
  .clk       (clk),
  .reset     (reset),
  .i_start   (i_start),
  .i_c_valid (o_c_valid),
  .i_done    (o_done)
);

// File: tests/matmul_tb.sv
`timescale 1ns/10ps

module matmul_tb;

  import matmul_pkg::*;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] base_a;
    logic [ADDR_WIDTH-1:0] base_b;
    logic [ADDR_WIDTH-1:0] base_c;
    logic [2:0]            fill;
    logic [7:0]            abort_at;
    logic                  expect_c;
  } run_entry_t;

  localparam logic [2:0] FILL_IDENT  = 3'd0;
  localparam logic [2:0] FILL_SMALL  = 3'd1;
  localparam logic [2:0] FILL_NEG    = 3'd2;
  localparam logic [2:0] FILL_SAT    = 3'd3;
  localparam logic [2:0] FILL_RANDOM = 3'd4;
  localparam int NUM_RUNS    = 8;
  localparam int CYCLE_LIMIT = NUM_RUNS * (DONE_CYCLE + 30) + 100;
  localparam int SAT_MAX     = 2 ** (DATA_WIDTH - 1) - 1;
  localparam int SAT_MIN     = -(2 ** (DATA_WIDTH - 1));

  // bases, fill kind, abort edge (0 runs to the end), results expected
  localparam run_entry_t RUN_TABLE [NUM_RUNS] = '{
    '{10'h000, 10'h100, 10'h200, FILL_IDENT,  8'd0, 1'b1},
    '{10'h010, 10'h120, 10'h230, FILL_SMALL,  8'd0, 1'b1},
    '{10'h040, 10'h140, 10'h240, FILL_NEG,    8'd0, 1'b1},
    '{10'h080, 10'h180, 10'h280, FILL_SAT,    8'd0, 1'b1},
    '{10'h0c0, 10'h1c0, 10'h2c0, FILL_SMALL,  8'd9, 1'b0},
    '{10'h004, 10'h104, 10'h204, FILL_RANDOM, 8'd0, 1'b1},
    '{10'h3f0, 10'h3e0, 10'h300, FILL_RANDOM, 8'd0, 1'b1},
    '{10'h050, 10'h060, 10'h070, FILL_RANDOM, 8'd0, 1'b1}
  };

  logic                  clk;
  logic                  reset;
  logic                  i_start;
  logic [ADDR_WIDTH-1:0] i_addr_a;
  logic [ADDR_WIDTH-1:0] i_addr_b;
  logic [ADDR_WIDTH-1:0] i_addr_c;
  logic [ROW_WIDTH-1:0]  i_a_data;
  logic [ROW_WIDTH-1:0]  i_b_data;
  logic [ADDR_WIDTH-1:0] o_a_addr;
  logic [ADDR_WIDTH-1:0] o_b_addr;
  logic [ADDR_WIDTH-1:0] o_c_addr;
  logic [ROW_WIDTH-1:0]  o_c_data;
  logic                  o_c_valid;
  logic                  o_done;

  logic [ROW_WIDTH-1:0]         mem_a [2**ADDR_WIDTH];
  logic [ROW_WIDTH-1:0]         mem_b [2**ADDR_WIDTH];
  logic [ROW_WIDTH-1:0]         a_pipe [MEM_LATENCY] = '{default: '0};
  logic [ROW_WIDTH-1:0]         b_pipe [MEM_LATENCY] = '{default: '0};
  logic signed [DATA_WIDTH-1:0] mat_a [MAT_SIZE][MAT_SIZE];
  logic signed [DATA_WIDTH-1:0] mat_b [MAT_SIZE][MAT_SIZE];
  logic [DATA_WIDTH-1:0]        exp_c [MAT_SIZE][MAT_SIZE];
  logic [31:0]                  lfsr_state;
  int                           cycle_count = 0;

  matmul_top matmul_top_inst (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_addr_a  (i_addr_a),
    .i_addr_b  (i_addr_b),
    .i_addr_c  (i_addr_c),
    .i_a_data  (i_a_data),
    .i_b_data  (i_b_data),
    .o_a_addr  (o_a_addr),
    .o_b_addr  (o_b_addr),
    .o_c_addr  (o_c_addr),
    .o_c_data  (o_c_data),
    .o_c_valid (o_c_valid),
    .o_done    (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // memories answer the registered address after MEM_LATENCY edges
  always @(posedge clk) begin
    a_pipe[0] <= mem_a[o_a_addr];
    b_pipe[0] <= mem_b[o_b_addr];
    for (int s = 1; s < MEM_LATENCY; s++) begin
      a_pipe[s] <= a_pipe[s-1];
      b_pipe[s] <= b_pipe[s-1];
    end
  end

  assign i_a_data = a_pipe[MEM_LATENCY-1];
  assign i_b_data = b_pipe[MEM_LATENCY-1];

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("simulation stopped, cycle limit of %0d reached", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "check failed");
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  task automatic random_byte(output logic [DATA_WIDTH-1:0] value);
    value = '0;
    for (int b = 0; b < DATA_WIDTH; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[DATA_WIDTH-2:0], lfsr_state[0]};
    end
  endtask

  task automatic fill_matrices(input logic [2:0] kind);
    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int c = 0; c < MAT_SIZE; c++) begin
        case (kind)
          FILL_IDENT: begin
            mat_a[r][c] = DATA_WIDTH'((r == c) ? 1 : 0);
            mat_b[r][c] = DATA_WIDTH'(r * MAT_SIZE + c - 7);
          end
          FILL_SMALL: begin
            mat_a[r][c] = DATA_WIDTH'(r + c + 1);
            mat_b[r][c] = DATA_WIDTH'(c - r);
          end
          FILL_NEG: begin
            mat_a[r][c] = DATA_WIDTH'(-(r + 1) * 3);
            mat_b[r][c] = DATA_WIDTH'(r - 2 * c - 1);
          end
          // products pin at both limits; column 3 sums wrap
          FILL_SAT: begin
            mat_a[r][c] = DATA_WIDTH'(((r + c) % 2 == 1) ? -100 : 100);
            mat_b[r][c] = DATA_WIDTH'((c == 0) ? 127 : (c == 1) ? -128 :
                                      (c == 2) ? 50 + r : (r % 2 == 1) ? -90 : 90);
          end
          default: begin
            random_byte(mat_a[r][c]);
            random_byte(mat_b[r][c]);
          end
        endcase
      end
    end
  endtask

  function automatic logic [DATA_WIDTH-1:0] sat_product(
    input logic signed [DATA_WIDTH-1:0] a,
    input logic signed [DATA_WIDTH-1:0] b
  );
    int product;
    product = int'(a) * int'(b);
    if (product > SAT_MAX) begin
      return DATA_WIDTH'(SAT_MAX);
    end else if (product < SAT_MIN) begin
      return DATA_WIDTH'(SAT_MIN);
    end
    return DATA_WIDTH'(product);
  endfunction

  // C[i][j] is the wrapping sum of the saturated products
  task automatic compute_expected();
    logic [DATA_WIDTH-1:0] acc;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        acc = '0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          acc = acc + sat_product(mat_a[i][k], mat_b[k][j]);
        end
        exp_c[i][j] = acc;
      end
    end
  endtask

  function automatic logic [ROW_WIDTH-1:0] expected_column(input int j);
    logic [ROW_WIDTH-1:0] word;
    for (int i = 0; i < MAT_SIZE; i++) begin
      word[i*DATA_WIDTH +: DATA_WIDTH] = exp_c[i][j];
    end
    return word;
  endfunction

  // A column k and B row k go to base plus 4k, lane 0 in the low byte
  task automatic load_memories(input run_entry_t entry);
    logic [ROW_WIDTH-1:0] word_a;
    logic [ROW_WIDTH-1:0] word_b;
    for (int k = 0; k < MAT_SIZE; k++) begin
      for (int l = 0; l < MAT_SIZE; l++) begin
        word_a[l*DATA_WIDTH +: DATA_WIDTH] = mat_a[l][k];
        word_b[l*DATA_WIDTH +: DATA_WIDTH] = mat_b[k][l];
      end
      mem_a[entry.base_a + ADDR_WIDTH'(MAT_SIZE * k)] = word_a;
      mem_b[entry.base_b + ADDR_WIDTH'(MAT_SIZE * k)] = word_b;
    end
  endtask

  task automatic idle_check(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      @(negedge clk);
      assert (!o_done && !o_c_valid)
        else report_mismatch("done or result strobe while start is low");
      assert (o_a_addr == i_addr_a - ADDR_WIDTH'(MAT_SIZE) &&
              o_b_addr == i_addr_b - ADDR_WIDTH'(MAT_SIZE) &&
              o_c_addr == i_addr_c - ADDR_WIDTH'(MAT_SIZE))
        else report_mismatch("idle addresses not parked at base minus one step");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table entry
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_entry(input run_entry_t entry);
    int                    col_seen;
    int                    done_seen;
    int                    last_valid;
    logic [ADDR_WIDTH-1:0] exp_addr;
    fill_matrices(entry.fill);
    compute_expected();
    load_memories(entry);
    @(posedge clk);
    i_addr_a <= entry.base_a;
    i_addr_b <= entry.base_b;
    i_addr_c <= entry.base_c;
    @(posedge clk);
    i_start <= 1'b1;
    col_seen = 0;
    done_seen = 0;
    last_valid = 0;
    // edge n is the nth edge that samples start high
    for (int n = 1; n <= DONE_CYCLE + 4; n++) begin
      @(posedge clk);
      if (entry.abort_at != 0 && n == int'(entry.abort_at)) begin
        i_start <= 1'b0;
      end
      @(negedge clk);
      if (n <= MAT_SIZE && (entry.abort_at == 0 || n < int'(entry.abort_at))) begin
        exp_addr = entry.base_a + ADDR_WIDTH'(MAT_SIZE * (n - 1));
        assert (o_a_addr == exp_addr)
          else report_mismatch($sformatf("A address %h, expected %h", o_a_addr, exp_addr));
        exp_addr = entry.base_b + ADDR_WIDTH'(MAT_SIZE * (n - 1));
        assert (o_b_addr == exp_addr)
          else report_mismatch($sformatf("B address %h, expected %h", o_b_addr, exp_addr));
      end
      if (o_c_valid) begin
        assert (entry.expect_c) else report_mismatch("result column in an aborted run");
        assert (col_seen < MAT_SIZE) else report_mismatch("too many result columns");
        assert (col_seen == 0 || last_valid == n - 1)
          else report_mismatch("result columns are not consecutive");
        exp_addr = entry.base_c + ADDR_WIDTH'(MAT_SIZE * col_seen);
        assert (o_c_addr == exp_addr)
          else report_mismatch($sformatf("C address %h, expected %h", o_c_addr, exp_addr));
        assert (o_c_data == expected_column(col_seen))
          else report_mismatch($sformatf("column %0d is %h, expected %h", col_seen,
                                         o_c_data, expected_column(col_seen)));
        col_seen++;
        last_valid = n;
      end
      if (o_done) begin
        assert (entry.expect_c && done_seen == 0 && !o_c_valid)
          else report_mismatch("unexpected done pulse");
        assert (n == DONE_CYCLE + 1)
          else report_mismatch($sformatf("done at edge %0d, expected %0d", n, DONE_CYCLE + 1));
        assert (col_seen == MAT_SIZE) else report_mismatch("done before all result columns");
        done_seen++;
      end
    end
    @(posedge clk);
    i_start <= 1'b0;
    assert (col_seen == (entry.expect_c ? MAT_SIZE : 0))
      else report_mismatch($sformatf("%0d result columns seen", col_seen));
    assert (done_seen == (entry.expect_c ? 1 : 0))
      else report_mismatch($sformatf("%0d done pulses seen", done_seen));
    idle_check(3);
  endtask

  initial begin
    reset <= 1'b1;
    i_start <= 1'b0;
    i_addr_a <= '0;
    i_addr_b <= '0;
    i_addr_c <= '0;
    lfsr_state = 32'hf710_3057;
    // background words vary with every address bit
    for (int x = 0; x < 2**ADDR_WIDTH; x++) begin
      mem_a[x] = {ADDR_WIDTH'(x), ~ADDR_WIDTH'(x), ADDR_WIDTH'(x), 2'b01};
      mem_b[x] = {~ADDR_WIDTH'(x), ADDR_WIDTH'(x), ~ADDR_WIDTH'(x), 2'b10};
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    idle_check(4);
    for (int e = 0; e < NUM_RUNS; e++) begin
      run_entry(RUN_TABLE[e]);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: tb.f
logic/matmul_pkg.sv
logic/processing_element.sv
logic/pe_array.sv
logic/operand_fetch.sv
logic/matmul_control.sv
logic/result_drain.sv
logic/matmul_top.sv
tests/matmul_sva.sv
tests/matmul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the matmul testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  -f tb.f --top-module matmul_tb -o matmul_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/matmul_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0
